/* hw/fp64Pkg.sv */
// Double format type, operand pair type, field widths, register map, FIFO depth
package fp64Pkg;

	// ====================
	// Double-precision format
	// ====================

	// Index of the top exponent bit
	localparam int EMSB = 10;
	// Index of the top stored significand bit
	localparam int FMSB = 51;

	// One IEEE-754 double, laid out as it sits in a 64-bit word
	typedef struct packed {
		logic sign;
		logic [EMSB:0] exp;
		logic [FMSB:0] sig;
	} FP64;

	// Operand pair handed from the bus side to the engine, a in the upper half
	typedef struct packed {
		FP64 a;
		FP64 b;
	} opPair_t;

	// Entries per FIFO and the matching pointer width
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_AW = 2;

	// ====================
	// Register map
	// ====================

	// Word addresses on the 3-bit bus address
	localparam logic [2:0] REG_ALO = 3'd0;
	localparam logic [2:0] REG_AHI = 3'd1;
	localparam logic [2:0] REG_BLO = 3'd2;
	localparam logic [2:0] REG_BHI = 3'd3;
	localparam logic [2:0] REG_GO = 3'd4;
	localparam logic [2:0] REG_RLO = 3'd5;
	localparam logic [2:0] REG_RHI = 3'd6;
	localparam logic [2:0] REG_STATUS = 3'd7;

	// Bit positions inside the status word
	localparam int ST_RVALID = 0;
	localparam int ST_OPFULL = 1;
	localparam int ST_OVF = 2;

	// Bit positions inside the 3-bit comparison code
	localparam int CMP_LT = 0;
	localparam int CMP_EQ = 1;
	localparam int CMP_UN = 2;

endpackage

/* hw/fpDecomp64.sv */
// Classifier flagging a double as zero, infinity or NaN
`timescale 1ns/1ps

module fpDecomp64 (
	input fp64Pkg::FP64 i,
	output logic zero,
	output logic inf,
	output logic nan
);

	// Exponent field is all ones for infinities and NaNs
	logic expMax;
	// Exponent field is all zeros for zeros and subnormals
	logic expMin;
	// Stored significand has no bit set
	logic sigNull;

	assign expMax = &i.exp;
	assign expMin = ~|i.exp;
	assign sigNull = ~|i.sig;

	// A zero of either sign has nothing in exponent or significand
	assign zero = expMin & sigNull;
	// Maximal exponent with an empty significand is an infinity
	assign inf = expMax & sigNull;
	// Maximal exponent with any payload bit is a NaN, quiet or signalling alike
	assign nan = expMax & ~sigNull;

	// The three classes are disjoint, so at most one flag may be raised
	flagsExclusive: assert final ($onehot0({zero, inf, nan}));

endmodule

/* hw/fpCompare64.sv */
// Comparator ordering two doubles into less, equal and unordered
`timescale 1ns/1ps

module fpCompare64 (
	input fp64Pkg::FP64 a,
	input fp64Pkg::FP64 b,
	output logic [2:0] cmp
);

	import fp64Pkg::*;

	logic zeroA;
	logic zeroB;
	logic nanA;
	logic nanB;
	logic bothZero;
	logic unordered;
	logic equal;
	logic lessRaw;
	// Magnitudes are exponent and significand taken together as one integer
	logic [EMSB+FMSB+1:0] magA;
	logic [EMSB+FMSB+1:0] magB;

	fpDecomp64 decompA (.i(a), .zero(zeroA), .inf(), .nan(nanA));
	fpDecomp64 decompB (.i(b), .zero(zeroB), .inf(), .nan(nanB));

	assign magA = {a.exp, a.sig};
	assign magB = {b.exp, b.sig};
	assign bothZero = zeroA & zeroB;

	// Any NaN makes the pair unordered
	assign unordered = nanA | nanB;
	// Identical patterns are equal, and so are +0 and -0
	assign equal = (a == b) | bothZero;

	// Signed-magnitude ordering
	always_comb begin
		if (a.sign != b.sign) begin
			// Negative below positive, except the two zeros
			lessRaw = a.sign & ~bothZero;
		end else if (a.sign) begin
			// Both negative so the larger magnitude is the smaller value
			lessRaw = magA > magB;
		end else begin
			lessRaw = magA < magB;
		end
	end

	// An unordered pair leaves less and equal clear
	assign cmp[CMP_UN] = unordered;
	assign cmp[CMP_EQ] = ~unordered & equal;
	assign cmp[CMP_LT] = ~unordered & lessRaw;

	ltEqExclusive: assert final (!(cmp[CMP_LT] && cmp[CMP_EQ]));

endmodule

/* hw/fpNextAfter64.sv */
// Two-stage nextafter pipeline for doubles with a clock enable
`timescale 1ns/1ps

module fpNextAfter64 (
	input logic clk,
	input logic arstN,
	input logic ce,
	input fp64Pkg::FP64 a,
	input fp64Pkg::FP64 b,
	output fp64Pkg::FP64 o
);

	import fp64Pkg::*;

	logic [2:0] cmp;
	logic aZero;
	logic aNan;
	// Neighbours of a, reached by stepping the raw 64-bit pattern
	FP64 aInc;
	FP64 aDec;
	// Smallest subnormal carrying the sign of b
	FP64 minSub;
	// Stage one choice and its register
	FP64 nextVal;
	FP64 stage1;

	fpCompare64 compareAB (.a(a), .b(b), .cmp(cmp));
	fpDecomp64 decompA (.i(a), .zero(aZero), .inf(), .nan(aNan));

	// Stepping the pattern carries through the exponent, so the largest
	// finite value rolls over into infinity and infinity back down
	assign aInc = FP64'(64'(a) + 64'd1);
	assign aDec = FP64'(64'(a) - 64'd1);
	assign minSub = {b.sign, {(EMSB + 1){1'b0}}, {FMSB{1'b0}}, 1'b1};

	// ====================
	// Stage one select
	// ====================

	always_comb begin
		if (cmp[CMP_UN]) begin
			// A NaN in a wins over a NaN in b
			nextVal = aNan ? a : b;
		end else if (cmp[CMP_EQ]) begin
			nextVal = a;
		end else if (aZero) begin
			// Leaving zero goes to the first subnormal toward b
			nextVal = minSub;
		end else if (cmp[CMP_LT] ^ a.sign) begin
			// Heading away from zero grows the magnitude
			nextVal = aInc;
		end else begin
			// Heading toward zero shrinks the magnitude
			nextVal = aDec;
		end
	end

	// ====================
	// Pipeline registers
	// ====================

	// Both stages hold their contents while ce is low
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			stage1 <= '0;
			o <= '0;
		end else if (ce) begin
			stage1 <= nextVal;
			o <= stage1;
		end
	end

endmodule

/* hw/syncFifo.sv */
// Synchronous first-word-fall-through FIFO with a type-parameter payload
`timescale 1ns/1ps

module syncFifo #(
	parameter type payload_t = fp64Pkg::FP64
) (
	input logic clk,
	input logic arstN,
	input logic push,
	input logic pop,
	input payload_t wrData,
	output payload_t rdData,
	output logic full,
	output logic empty,
	output logic [fp64Pkg::FIFO_AW:0] count
);

	import fp64Pkg::*;

	// Storage needs no reset since count says which slots are live
	payload_t mem [FIFO_DEPTH];
	// Pointers wrap on their own because the depth is a power of two
	logic [FIFO_AW-1:0] wrPtr;
	logic [FIFO_AW-1:0] rdPtr;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wrPtr] <= wrData;
		end
	end

	// ====================
	// Pointers and occupancy
	// ====================

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			// Simultaneous push and pop leave the occupancy unchanged
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	// Head is visible combinationally
	assign rdData = mem[rdPtr];
	assign empty = (count == '0);
	assign full = (count == (FIFO_AW + 1)'(FIFO_DEPTH));

	noPushFull: assert property (@(posedge clk) disable iff (!arstN) !(push && full));
	noPopEmpty: assert property (@(posedge clk) disable iff (!arstN) !(pop && empty));

endmodule

/* hw/nextAfterWbSlave.sv */
// Wishbone classic register front end producing operand pairs and reading results
`timescale 1ns/1ps

module nextAfterWbSlave (
	input logic clk,
	input logic arstN,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [2:0] adr,
	input logic [31:0] datIn,
	output logic ack,
	output logic [31:0] datOut,
	output logic opPush,
	output fp64Pkg::opPair_t opData,
	input logic opFull,
	output logic resPop,
	input fp64Pkg::FP64 resData,
	input logic resEmpty
);

	import fp64Pkg::*;

	// Operand halves as written by the host
	logic [31:0] aLo;
	logic [31:0] aHi;
	logic [31:0] bLo;
	logic [31:0] bHi;
	// Sticky flag for a go that found the operand FIFO full
	logic ovf;
	// Qualified access strobes, valid only in the ack cycle
	logic wrAck;
	logic rdAck;
	logic goHit;
	logic [31:0] status;

	// ====================
	// Bus handshake
	// ====================

	// Ack follows the strobe by one cycle and drops after one cycle,
	// the master releases stb before starting the next access
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ack <= 1'b0;
		end else begin
			ack <= cyc & stb & ~ack;
		end
	end

	assign wrAck = ack & we;
	assign rdAck = ack & ~we;
	assign goHit = wrAck & (adr == REG_GO);

	// Operand registers are plain payload and only change on a write
	always_ff @(posedge clk) begin
		if (wrAck) begin
			case (adr)
				REG_ALO: aLo <= datIn;
				REG_AHI: aHi <= datIn;
				REG_BLO: bLo <= datIn;
				REG_BHI: bHi <= datIn;
				default: ;
			endcase
		end
	end

	// ====================
	// FIFO side
	// ====================

	// Pair layout puts a above b, each with its high word first
	assign opData = {aHi, aLo, bHi, bLo};
	assign opPush = goHit & ~opFull;
	// Reading the high result word retires the head entry
	assign resPop = rdAck & (adr == REG_RHI) & ~resEmpty;

	// Overflow is set by a refused go and cleared by reading status
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ovf <= 1'b0;
		end else if (goHit & opFull) begin
			ovf <= 1'b1;
		end else if (rdAck & (adr == REG_STATUS)) begin
			ovf <= 1'b0;
		end
	end

	always_comb begin
		status = '0;
		status[ST_RVALID] = ~resEmpty;
		status[ST_OPFULL] = opFull;
		status[ST_OVF] = ovf;
	end

	// Read mux, results read as zero while the result FIFO is empty
	always_comb begin
		case (adr)
			REG_ALO: datOut = aLo;
			REG_AHI: datOut = aHi;
			REG_BLO: datOut = bLo;
			REG_BHI: datOut = bHi;
			REG_RLO: datOut = resEmpty ? 32'd0 : resData[31:0];
			REG_RHI: datOut = resEmpty ? 32'd0 : resData[63:32];
			REG_STATUS: datOut = status;
			default: datOut = 32'd0;
		endcase
	end

	// The master must still be holding the cycle when ack arrives
	ackInCycle: assert property (@(posedge clk) disable iff (!arstN) ack |-> cyc && stb);

endmodule

/* hw/nextAfterEngine.sv */
// Engine draining operand pairs through the nextafter pipeline into the result FIFO
`timescale 1ns/1ps

module nextAfterEngine (
	input logic clk,
	input logic arstN,
	input logic opEmpty,
	input fp64Pkg::opPair_t opData,
	output logic opPop,
	input logic [fp64Pkg::FIFO_AW:0] resCount,
	output logic resPush,
	output fp64Pkg::FP64 resData
);

	import fp64Pkg::*;

	// Valid bits shadowing the two pipeline stages
	logic [1:0] vld;
	// Results already stored plus those still inside the pipeline
	logic [FIFO_AW+1:0] pending;
	logic ce;

	assign pending = resCount + vld[0] + vld[1];

	// Freeze everything once every result slot is spoken for, so an item
	// leaving the pipeline always has room in the result FIFO
	assign ce = (pending < FIFO_DEPTH);

	assign opPop = ce & ~opEmpty;
	assign resPush = ce & vld[1];

	fpNextAfter64 pipe (
		.clk(clk),
		.arstN(arstN),
		.ce(ce),
		.a(opData.a),
		.b(opData.b),
		.o(resData)
	);

	// Valid bits advance together with the data stages
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			vld <= 2'b00;
		end else if (ce) begin
			vld <= {vld[0], opPop};
		end
	end

	// Result FIFO space is reserved before the pop, so it cannot be full here
	resRoom: assert property (@(posedge clk) disable iff (!arstN)
		resPush |-> resCount < FIFO_DEPTH);

endmodule

/* hw/nextAfterTop.sv */
// Top level joining the bus slave, the two FIFOs and the nextafter engine
`timescale 1ns/1ps

module nextAfterTop (
	input logic clk,
	input logic arstN,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [2:0] adr,
	input logic [31:0] datIn,
	output logic ack,
	output logic [31:0] datOut
);

	import fp64Pkg::*;

	// Operand path from slave to engine
	logic opPush;
	logic opPop;
	logic opFull;
	logic opEmpty;
	opPair_t opWrData;
	opPair_t opRdData;
	// Result path from engine back to slave
	logic resPush;
	logic resPop;
	logic resEmpty;
	logic [FIFO_AW:0] resCount;
	FP64 resWrData;
	FP64 resRdData;

	nextAfterWbSlave wbSlave (
		.clk(clk), .arstN(arstN),
		.cyc(cyc), .stb(stb), .we(we), .adr(adr), .datIn(datIn),
		.ack(ack), .datOut(datOut),
		.opPush(opPush), .opData(opWrData), .opFull(opFull),
		.resPop(resPop), .resData(resRdData), .resEmpty(resEmpty)
	);

	syncFifo #(.payload_t(opPair_t)) opFifo (
		.clk(clk), .arstN(arstN), .push(opPush), .pop(opPop),
		.wrData(opWrData), .rdData(opRdData),
		.full(opFull), .empty(opEmpty), .count()
	);

	nextAfterEngine engine (
		.clk(clk), .arstN(arstN),
		.opEmpty(opEmpty), .opData(opRdData), .opPop(opPop),
		.resCount(resCount), .resPush(resPush), .resData(resWrData)
	);

	syncFifo #(.payload_t(FP64)) resFifo (
		.clk(clk), .arstN(arstN), .push(resPush), .pop(resPop),
		.wrData(resWrData), .rdData(resRdData),
		.full(), .empty(resEmpty), .count(resCount)
	);

endmodule

/* verif/nextAfterTb.sv */
// Directed testbench for the nextafter unit with reference model, bus tasks and watchdog
`timescale 1ns/1ps

module nextAfterTb;

	import fp64Pkg::*;

	localparam int CLK_NS = 40;
	localparam int NUM_TESTS = 5;
	localparam int WATCHDOG_CYCLES = 2000;
	localparam int ACK_LIMIT = 16;
	localparam int POLL_LIMIT = 200;

	logic clk;
	logic arstN;
	logic cyc;
	logic stb;
	logic we;
	logic [2:0] adr;
	logic [31:0] datIn;
	logic ack;
	logic [31:0] datOut;
	integer seed;
	int errCount;
	int testsRun;
	int testsFailed;

	nextAfterTop dut0 (
		.clk(clk), .arstN(arstN),
		.cyc(cyc), .stb(stb), .we(we), .adr(adr), .datIn(datIn),
		.ack(ack), .datOut(datOut)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	// Budget scales with the number of tests
	initial begin
		#(NUM_TESTS * WATCHDOG_CYCLES * CLK_NS);
		$display("Timeout: tests did not finish within %0d clock cycles",
			NUM_TESTS * WATCHDOG_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

	// ====================
	// Reference model
	// ====================

	function automatic FP64 refNextAfter(FP64 a, FP64 b);
		logic [63:0] bits;
		logic signed [64:0] keyA;
		logic signed [64:0] keyB;
		logic aZero;
		logic bZero;
		bits = a;
		aZero = (a[62:0] == '0);
		bZero = (b[62:0] == '0);
		// Signed keys order the values as real numbers, zeros collapse to one key
		keyA = a.sign ? -$signed({2'b00, a[62:0]}) : $signed({2'b00, a[62:0]});
		keyB = b.sign ? -$signed({2'b00, b[62:0]}) : $signed({2'b00, b[62:0]});
		if (a.exp == '1 && a.sig != '0) return a;
		if (b.exp == '1 && b.sig != '0) return b;
		if (bits == b || (aZero && bZero)) return a;
		if (aZero) return {b.sign, 63'd1};
		// Away from zero when b lies above a positive a or below a negative a
		if ((keyB > keyA) != a.sign) return bits + 64'd1;
		return bits - 64'd1;
	endfunction

	// ====================
	// Bus and check tasks
	// ====================

	// One classic cycle, held through the edge that ends ack
	task automatic busCycle(input logic write, input logic [2:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int waitCycles;
		waitCycles = 0;
		rdata = '0;
		@(negedge clk);
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = addr;
		datIn = wdata;
		@(negedge clk);
		while (!ack && waitCycles < ACK_LIMIT) begin
			@(negedge clk);
			waitCycles++;
		end
		if (!ack) begin
			$display("Bus access to address %0d was never acknowledged", addr);
			errCount++;
		end else begin
			rdata = datOut;
		end
		@(negedge clk);
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic wbWrite(input logic [2:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		busCycle(1'b1, addr, data, unused);
	endtask

	task automatic wbRead(input logic [2:0] addr, output logic [31:0] data);
		busCycle(1'b0, addr, 32'd0, data);
	endtask

	task automatic checkFp64(input string name, input FP64 got, input FP64 expected);
		if (got !== expected) begin
			$display("mismatch %s: got %h expected %h", name, got, expected);
			errCount++;
		end
	endtask

	task automatic checkWord(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("mismatch %s: got %h expected %h", name, got, expected);
			errCount++;
		end
	endtask

	task automatic submitPair(input FP64 a, input FP64 b);
		wbWrite(REG_ALO, a[31:0]);
		wbWrite(REG_AHI, a[63:32]);
		wbWrite(REG_BLO, b[31:0]);
		wbWrite(REG_BHI, b[63:32]);
		wbWrite(REG_GO, 32'd0);
	endtask

	// Polls status until a result is waiting or the poll budget runs out
	task automatic waitForResult(output logic [31:0] st);
		int polls;
		polls = 0;
		wbRead(REG_STATUS, st);
		while (!st[ST_RVALID] && polls < POLL_LIMIT) begin
			wbRead(REG_STATUS, st);
			polls++;
		end
	endtask

	task automatic fetchResult(output FP64 r);
		logic [31:0] st;
		logic [31:0] lo;
		logic [31:0] hi;
		waitForResult(st);
		r = '0;
		if (!st[ST_RVALID]) begin
			$display("No result became available after %0d status polls", POLL_LIMIT);
			errCount++;
		end else begin
			wbRead(REG_RLO, lo);
			wbRead(REG_RHI, hi);
			r = {hi, lo};
		end
	endtask

	task automatic runPair(input string name, input FP64 a, input FP64 b);
		FP64 got;
		submitPair(a, b);
		fetchResult(got);
		checkFp64(name, got, refNextAfter(a, b));
	endtask

	task automatic applyReset();
		arstN = 1'b0;
		repeat (16) @(negedge clk);
		arstN = 1'b1;
	endtask

	task automatic finishTest(input string name, input int errorsBefore);
		testsRun++;
		if (errCount == errorsBefore) begin
			$display("test %s: ok", name);
		end else begin
			testsFailed++;
			$display("test %s: %0d errors", name, errCount - errorsBefore);
		end
	endtask

	// ====================
	// Directed tests
	// ====================

	task automatic testOrdinary();
		int startErr;
		startErr = errCount;
		// A couple of hand-derived patterns keep the model itself honest
		checkFp64("ref 1.0 up", refNextAfter($realtobits(1.0), $realtobits(2.0)),
			64'h3FF0_0000_0000_0001);
		checkFp64("ref -1.0 to zero", refNextAfter($realtobits(-1.0), 64'd0),
			64'hBFEF_FFFF_FFFF_FFFF);
		runPair("1.0 toward 2.0", $realtobits(1.0), $realtobits(2.0));
		runPair("-1.0 toward 0", $realtobits(-1.0), 64'd0);
		runPair("3.75 down", $realtobits(3.75), $realtobits(-2.0));
		runPair("-5.5 down", $realtobits(-5.5), $realtobits(-1.0e10));
		runPair("tiny up", $realtobits(1.0e-300), $realtobits(1.0));
		finishTest("ordinary steps", startErr);
	endtask

	task automatic testSpecial();
		int startErr;
		startErr = errCount;
		runPair("+0 toward +", 64'h0, $realtobits(1.0));
		runPair("+0 toward -", 64'h0, $realtobits(-1.0));
		runPair("-0 toward +", 64'h8000_0000_0000_0000, $realtobits(1.0));
		runPair("-0 toward -", 64'h8000_0000_0000_0000, $realtobits(-3.0));
		runPair("equal", $realtobits(3.5), $realtobits(3.5));
		runPair("+0 vs -0", 64'h0, 64'h8000_0000_0000_0000);
		runPair("nan in a", 64'h7FF8_0000_0000_0001, 64'hFFF8_0000_0000_0002);
		runPair("nan in b", $realtobits(1.0), 64'h7FF8_0000_0000_0000);
		runPair("max to inf", 64'h7FEF_FFFF_FFFF_FFFF, 64'h7FF0_0000_0000_0000);
		runPair("inf to zero", 64'h7FF0_0000_0000_0000, 64'h0);
		finishTest("special operands", startErr);
	endtask

	task automatic testRandom();
		int startErr;
		FP64 a;
		FP64 b;
		startErr = errCount;
		for (int i = 0; i < 20; i++) begin
			a = {$random(seed), $random(seed)};
			b = {$random(seed), $random(seed)};
			runPair("random result", a, b);
		end
		finishTest("random streaming", startErr);
	endtask

	task automatic testBuffering();
		int startErr;
		FP64 expQ[$];
		FP64 a;
		FP64 b;
		FP64 got;
		logic [31:0] st;
		startErr = errCount;
		// Pipeline plus result FIFO hold one FIFO's worth, the operand FIFO the rest
		for (int i = 0; i < 2 * FIFO_DEPTH; i++) begin
			a = $realtobits(i + 0.5);
			b = (i % 2) ? $realtobits(-1000.0) : $realtobits(1000.0);
			submitPair(a, b);
			expQ.push_back(refNextAfter(a, b));
		end
		wbRead(REG_STATUS, st);
		checkWord("status when full", st, 32'h3);
		wbWrite(REG_GO, 32'd0);
		wbRead(REG_STATUS, st);
		checkWord("status after dropped go", st, 32'h7);
		wbRead(REG_STATUS, st);
		checkWord("status after overflow clear", st, 32'h3);
		while (expQ.size() > 0) begin
			fetchResult(got);
			checkFp64("drained result", got, expQ.pop_front());
		end
		wbRead(REG_STATUS, st);
		checkWord("status after drain", st, 32'h0);
		finishTest("buffering", startErr);
	endtask

	task automatic testEmptyReset();
		int startErr;
		logic [31:0] word;
		startErr = errCount;
		// Leave a finished result waiting so that reset has state to clear
		submitPair($realtobits(1.0), $realtobits(2.0));
		waitForResult(word);
		checkWord("status before reset", word, 32'h1);
		applyReset();
		wbRead(REG_STATUS, word);
		checkWord("status after reset", word, 32'h0);
		wbRead(REG_RLO, word);
		checkWord("empty result low", word, 32'h0);
		wbRead(REG_RHI, word);
		checkWord("empty result high", word, 32'h0);
		runPair("result after empty reads", $realtobits(2.5), 64'h0);
		wbRead(REG_STATUS, word);
		checkWord("status at end", word, 32'h0);
		finishTest("empty and reset state", startErr);
	endtask

	initial begin
		seed = 9;
		errCount = 0;
		testsRun = 0;
		testsFailed = 0;
		arstN = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = 3'd0;
		datIn = 32'd0;
		applyReset();
		testOrdinary();
		testSpecial();
		testRandom();
		testBuffering();
		testEmptyReset();
		$display("summary: %0d tests run, %0d failed, %0d errors", testsRun, testsFailed,
			errCount);
		if (errCount == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* tb.f */
hw/fp64Pkg.sv
hw/fpDecomp64.sv
hw/fpCompare64.sv
hw/fpNextAfter64.sv
hw/syncFifo.sv
hw/nextAfterWbSlave.sv
hw/nextAfterEngine.sv
hw/nextAfterTop.sv
verif/nextAfterTb.sv
